// ==== rtl/ex_pkg.sv ====
// execute stage package with shared widths, data types and operation codes

package ex_pkg;

  // data and index types
  typedef logic [63:0] word_t;
  typedef logic [63:0] pc_t;
  typedef logic [4:0]  gpr_addr_t;
  typedef logic [11:0] csr_addr_t;

  // bus widths
  localparam int DS_TO_ES_BUS_WD = 359;
  localparam int ES_TO_MS_BUS_WD = 216;
  localparam int WMASK_WD        = 8;

  typedef logic [4:0] alu_op_t;

  localparam alu_op_t ALU_ADD   = 5'd0;
  localparam alu_op_t ALU_SUB   = 5'd1;
  localparam alu_op_t ALU_SLL   = 5'd2;
  localparam alu_op_t ALU_SLT   = 5'd3;
  localparam alu_op_t ALU_SLTU  = 5'd4;
  localparam alu_op_t ALU_XOR   = 5'd5;
  localparam alu_op_t ALU_SRL   = 5'd6;
  localparam alu_op_t ALU_SRA   = 5'd7;
  localparam alu_op_t ALU_OR    = 5'd8;
  localparam alu_op_t ALU_AND   = 5'd9;
  localparam alu_op_t ALU_PASS2 = 5'd10;  // lui

  // funct3 encoding where immediate forms have bit 2 set
  typedef logic [2:0] csr_op_t;

  localparam csr_op_t CSR_RW  = 3'd1;
  localparam csr_op_t CSR_RS  = 3'd2;
  localparam csr_op_t CSR_RC  = 3'd3;
  localparam csr_op_t CSR_RWI = 3'd5;
  localparam csr_op_t CSR_RSI = 3'd6;
  localparam csr_op_t CSR_RCI = 3'd7;

  // store size as riscv funct3
  typedef logic [2:0] mem_op_t;

  localparam mem_op_t MEM_B = 3'd0;
  localparam mem_op_t MEM_H = 3'd1;
  localparam mem_op_t MEM_W = 3'd2;
  localparam mem_op_t MEM_D = 3'd3;

  // alu operand 2 select where code 3 behaves as imm
  localparam logic [1:0] SRC2_RS2  = 2'd0;
  localparam logic [1:0] SRC2_IMM  = 2'd1;
  localparam logic [1:0] SRC2_FOUR = 2'd2;

endpackage

// ==== rtl/ex_alu.sv ====
// ex_alu 64-bit integer alu with 32-bit word cut and sign extension

module ex_alu import ex_pkg::*; (
  input  word_t   i_src1,
  input  word_t   i_src2,
  input  alu_op_t i_op,
  input  logic    i_word_cut,
  output word_t   o_result
);

  logic [5:0] shamt;
  word_t      srl_src;
  word_t      sra_src;
  word_t      sum;
  word_t      diff;
  word_t      result;

  // word mode shifts use 5 bits of shift amount
  assign shamt = i_word_cut ? {1'b0, i_src2[4:0]} : i_src2[5:0];

  // right shifts in word mode act on the low half only
  assign srl_src = i_word_cut ? {32'b0, i_src1[31:0]} : i_src1;
  assign sra_src = i_word_cut ? {{32{i_src1[31]}}, i_src1[31:0]} : i_src1;

  assign sum  = i_src1 + i_src2;
  assign diff = i_src1 - i_src2;

  always_comb begin
    case (i_op)
      ALU_ADD: begin
        result = sum;
      end
      ALU_SUB: begin
        result = diff;
      end
      ALU_SLL: begin
        result = i_src1 << shamt;  // low 32 bits already right for sllw
      end
      ALU_SLT: begin
        result = {63'b0, $signed(i_src1) < $signed(i_src2)};
      end
      ALU_SLTU: begin
        result = {63'b0, i_src1 < i_src2};
      end
      ALU_XOR: begin
        result = i_src1 ^ i_src2;
      end
      ALU_SRL: begin
        result = srl_src >> shamt;
      end
      ALU_SRA: begin
        result = $unsigned($signed(sra_src) >>> shamt);
      end
      ALU_OR: begin
        result = i_src1 | i_src2;
      end
      ALU_AND: begin
        result = i_src1 & i_src2;
      end
      ALU_PASS2: begin
        result = i_src2;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // sign extend the low word in word mode
  assign o_result = i_word_cut ? {{32{result[31]}}, result[31:0]} : result;

endmodule

// ==== rtl/ex_exu.sv ====
// ex_exu execute unit with alu operand select and csr write value

module ex_exu import ex_pkg::*; (
  input  word_t      i_rs1data,
  input  word_t      i_rs2data,
  input  word_t      i_imm,
  input  pc_t        i_pc,
  input  word_t      i_csrrdata,
  input  logic       i_alu_src1_sel,
  input  logic [1:0] i_alu_src2_sel,
  input  alu_op_t    i_alu_op,
  input  logic       i_alu_word_cut_sel,
  input  csr_op_t    i_csr_op,
  output word_t      o_alu_result,
  output word_t      o_csr_result
);

  word_t alu_src1;
  word_t alu_src2;
  word_t csr_src;
  logic  csr_imm_form;

  assign alu_src1 = i_alu_src1_sel ? i_pc : i_rs1data;  // 1 picks pc (auipc, jal)

  always_comb begin
    case (i_alu_src2_sel)
      SRC2_RS2:  alu_src2 = i_rs2data;
      SRC2_IMM:  alu_src2 = i_imm;
      SRC2_FOUR: alu_src2 = 64'd4;  // link address
      default:   alu_src2 = i_imm;
    endcase
  end

  ex_alu u_alu (
    .i_src1     (alu_src1),
    .i_src2     (alu_src2),
    .i_op       (i_alu_op),
    .i_word_cut (i_alu_word_cut_sel),
    .o_result   (o_alu_result)
  );

  assign csr_imm_form = (i_csr_op == CSR_RWI) || (i_csr_op == CSR_RSI) || (i_csr_op == CSR_RCI);
  assign csr_src      = csr_imm_form ? i_imm : i_rs1data;  // zimm comes in on imm

  always_comb begin
    case (i_csr_op)
      CSR_RW, CSR_RWI: o_csr_result = csr_src;
      CSR_RS, CSR_RSI: o_csr_result = i_csrrdata | csr_src;
      CSR_RC, CSR_RCI: o_csr_result = i_csrrdata & ~csr_src;
      default:         o_csr_result = i_csrrdata;  // no csr change
    endcase
  end

endmodule

// ==== rtl/ex_lsu_store.sv ====
// ex_lsu_store store formatter with byte write mask and lane-aligned write data

module ex_lsu_store import ex_pkg::*; (
  input  mem_op_t             i_mem_op,
  input  logic [2:0]          i_waddr_align,
  input  word_t               i_wdata,
  output logic [WMASK_WD-1:0] o_wmask,
  output word_t               o_wdata
);

  logic [WMASK_WD-1:0] base_mask;
  logic [5:0]          lane_shift;

  always_comb begin
    case (i_mem_op)
      MEM_B: begin
        base_mask = 8'h01;
      end
      MEM_H: begin
        base_mask = 8'h03;
      end
      MEM_W: begin
        base_mask = 8'h0f;
      end
      MEM_D: begin
        base_mask = 8'hff;
      end
      default: begin
        base_mask = 8'h00;  // not a store
      end
    endcase
  end

  // byte offset to bit offset
  assign lane_shift = {i_waddr_align, 3'b000};

  assign o_wmask = base_mask << i_waddr_align;
  assign o_wdata = i_wdata << lane_shift;  // bytes above the size are masked off

endmodule

// ==== rtl/ex_stage.sv ====
// ex_stage execute pipeline stage with decode handshake, alu, csr value and data sram request

module ex_stage import ex_pkg::*; #(
  parameter int SRAM_ADDR_WD = 32
) (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  // allowin
  input  logic                       i_ms_allowin,
  output logic                       o_es_allowin,
  // from decode
  input  logic                       i_ds_to_es_valid,
  input  logic [DS_TO_ES_BUS_WD-1:0] i_ds_to_es_bus,
  // to memory stage
  output logic                       o_es_to_ms_valid,
  output logic [ES_TO_MS_BUS_WD-1:0] o_es_to_ms_bus,
  // data sram request
  output logic [SRAM_ADDR_WD-1:0]    o_data_sram_addr,
  output logic                       o_data_sram_ren,
  output logic                       o_data_sram_wen,
  output logic [WMASK_WD-1:0]        o_data_sram_wmask,
  output word_t                      o_data_sram_wdata,
  output logic                       o_halt
);

  logic                       es_valid;
  logic [DS_TO_ES_BUS_WD-1:0] ds_to_es_bus_r;

  word_t      es_rs1data;
  word_t      es_rs2data;
  word_t      es_csrrdata;
  word_t      es_imm;
  pc_t        es_pc;
  logic       es_alu_src1_sel;
  logic [1:0] es_alu_src2_sel;
  logic       es_alu_word_cut_sel;
  alu_op_t    es_alu_op;
  gpr_addr_t  es_rd;
  csr_addr_t  es_csr;
  logic       es_gpr_wen;
  logic       es_csr_wen;
  logic       es_mem_ren;
  logic       es_mem_wen;
  mem_op_t    es_mem_op;
  logic       es_csr_inst_sel;  // gpr gets the old csr value
  csr_op_t    es_csr_op;
  logic       es_ebreak_sel;
  logic       es_invalid_inst_sel;

  word_t es_alu_result;
  word_t es_csr_result;

  // single cycle execute, ready-go is always 1
  assign o_es_allowin     = !es_valid || i_ms_allowin;
  assign o_es_to_ms_valid = es_valid;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      es_valid <= 1'b0;
    end else if (o_es_allowin) begin
      es_valid <= i_ds_to_es_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ds_to_es_valid && o_es_allowin) begin
      ds_to_es_bus_r <= i_ds_to_es_bus;
    end
  end

  assign {es_rs1data, es_rs2data, es_csrrdata, es_imm, es_pc,  // 358:39
          es_alu_src1_sel, es_alu_src2_sel, es_alu_word_cut_sel, es_alu_op,
          es_rd, es_csr,
          es_gpr_wen, es_csr_wen, es_mem_ren, es_mem_wen, es_mem_op,
          es_csr_inst_sel, es_csr_op,
          es_ebreak_sel, es_invalid_inst_sel} = ds_to_es_bus_r;

  ex_exu u_exu (
    .i_rs1data          (es_rs1data),
    .i_rs2data          (es_rs2data),
    .i_imm              (es_imm),
    .i_pc               (es_pc),
    .i_csrrdata         (es_csrrdata),
    .i_alu_src1_sel     (es_alu_src1_sel),
    .i_alu_src2_sel     (es_alu_src2_sel),
    .i_alu_op           (es_alu_op),
    .i_alu_word_cut_sel (es_alu_word_cut_sel),
    .i_csr_op           (es_csr_op),
    .o_alu_result       (es_alu_result),
    .o_csr_result       (es_csr_result)
  );

  ex_lsu_store u_lsu_store (
    .i_mem_op      (es_mem_op),
    .i_waddr_align (es_alu_result[2:0]),  // rs1 + imm
    .i_wdata       (es_rs2data),
    .o_wmask       (o_data_sram_wmask),
    .o_wdata       (o_data_sram_wdata)
  );

  assign o_data_sram_addr = es_alu_result[SRAM_ADDR_WD-1:0];
  assign o_data_sram_ren  = es_mem_ren && es_valid;
  assign o_data_sram_wen  = es_mem_wen && es_valid;

  assign o_halt = es_valid && (es_ebreak_sel || es_invalid_inst_sel);

  assign o_es_to_ms_bus = {es_rd, es_csr, es_gpr_wen, es_csr_wen, es_mem_ren, es_mem_op,
                           es_csr_inst_sel, es_csrrdata, es_alu_result, es_csr_result};

endmodule

// ==== bench/ex_stage_asserts.sv ====
// ex_stage assertions on handshake stability, sram enables and reset state

module ex_stage_asserts import ex_pkg::*; (
  input logic                       i_clk,
  input logic                       i_rst_n,
  input logic                       i_ms_allowin,
  input logic                       o_es_allowin,
  input logic                       o_es_to_ms_valid,
  input logic [ES_TO_MS_BUS_WD-1:0] o_es_to_ms_bus,
  input logic                       o_data_sram_ren,
  input logic                       o_data_sram_wen,
  input logic                       o_halt
);
  timeunit 1ns;
  timeprecision 1ps;

  a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_es_to_ms_valid && !i_ms_allowin |=> o_es_to_ms_valid && $stable(o_es_to_ms_bus))
    else $error("output not held under back-pressure");

  a_en_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_data_sram_ren || o_data_sram_wen) |-> o_es_to_ms_valid)
    else $error("sram enable without a valid instruction");

  a_reset: assert property (@(posedge i_clk)
    !i_rst_n |=> !o_es_to_ms_valid && !o_data_sram_ren && !o_data_sram_wen && !o_halt
      && o_es_allowin)
    else $error("outputs active after reset");

endmodule

bind ex_stage ex_stage_asserts u_asserts (.*);

// ==== bench/ex_stage_tb.sv ====
// ex_stage testbench with lfsr stimulus, reference model and in-order scoreboard

module ex_stage_tb import ex_pkg::*; ;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_ALU   = 200;
  localparam int N_STORE = 32;  // 4 sizes x 8 offsets
  localparam int N_HS    = 200;
  localparam int LIMIT   = 4 * (N_ALU + N_STORE + N_HS) + 8;
  localparam int ITEM_WD = ES_TO_MS_BUS_WD + 32 + 2 + WMASK_WD + 64 + 1;

  logic                       clk;
  logic                       rst_n;
  logic                       ms_allowin;
  logic                       es_allowin;
  logic                       ds_valid;
  logic [DS_TO_ES_BUS_WD-1:0] ds_bus;
  logic                       es_valid;
  logic [ES_TO_MS_BUS_WD-1:0] es_bus;
  logic [31:0]                sram_addr;
  logic                       sram_ren;
  logic                       sram_wen;
  logic [WMASK_WD-1:0]        sram_wmask;
  word_t                      sram_wdata;
  logic                       halt;

  // fields of the instruction being driven
  word_t     f_rs1, f_rs2, f_csrr, f_imm, f_pc;
  logic      f_s1, f_wc, f_gw, f_cw, f_mr, f_mw, f_cis, f_eb, f_inv;
  logic [1:0] f_s2;
  alu_op_t   f_op;
  gpr_addr_t f_rd;
  csr_addr_t f_csr;
  mem_op_t   f_mop;
  csr_op_t   f_cop;

  logic [31:0]        lfsr;
  logic [ITEM_WD-1:0] exp_q[$];
  bit                 acc = 1'b0;
  int                 errors = 0;
  int                 tests_passed = 0;
  int                 tests_failed = 0;
  int                 cycles = 0;

  ex_stage ex_stage_inst (
    .i_clk             (clk),
    .i_rst_n           (rst_n),
    .i_ms_allowin      (ms_allowin),
    .o_es_allowin      (es_allowin),
    .i_ds_to_es_valid  (ds_valid),
    .i_ds_to_es_bus    (ds_bus),
    .o_es_to_ms_valid  (es_valid),
    .o_es_to_ms_bus    (es_bus),
    .o_data_sram_addr  (sram_addr),
    .o_data_sram_ren   (sram_ren),
    .o_data_sram_wen   (sram_wen),
    .o_data_sram_wmask (sram_wmask),
    .o_data_sram_wdata (sram_wdata),
    .o_halt            (halt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [63:0] rnd(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic word_t alu_model();
    word_t a, b, r;
    logic [5:0] sh;
    logic signed [31:0] lo;
    a = f_s1 ? f_pc : f_rs1;
    b = (f_s2 == 2'd0) ? f_rs2 : (f_s2 == 2'd2) ? 64'd4 : f_imm;
    sh = f_wc ? {1'b0, b[4:0]} : b[5:0];
    case (f_op)
      ALU_ADD:   r = a + b;
      ALU_SUB:   r = a - b;
      ALU_SLL:   r = a << sh;
      ALU_SLT:   r = {63'b0, $signed(a) < $signed(b)};
      ALU_SLTU:  r = {63'b0, a < b};
      ALU_XOR:   r = a ^ b;
      ALU_SRL:   r = f_wc ? {32'b0, a[31:0] >> sh} : a >> sh;
      ALU_SRA: begin
        lo = $signed(a[31:0]) >>> sh;
        r = f_wc ? {32'b0, lo} : $unsigned($signed(a) >>> sh);
      end
      ALU_OR:    r = a | b;
      ALU_AND:   r = a & b;
      ALU_PASS2: r = b;
      default:   r = '0;
    endcase
    if (f_wc) r = {{32{r[31]}}, r[31:0]};
    return r;
  endfunction

  function automatic word_t csr_model();
    word_t src;
    src = f_cop[2] ? f_imm : f_rs1;  // immediate forms
    case (f_cop[1:0])
      2'd1:    return src;
      2'd2:    return f_csrr | src;
      2'd3:    return f_csrr & ~src;
      default: return f_csrr;
    endcase
  endfunction

  // bus, addr, ren, wen, wmask, wdata, halt
  function automatic logic [ITEM_WD-1:0] expected_item();
    word_t      alu;
    logic [2:0] off;
    logic [7:0] m;
    alu = alu_model();
    off = alu[2:0];
    m = 8'((9'd1 << (4'd1 << f_mop[1:0])) - 9'd1);
    return {f_rd, f_csr, f_gw, f_cw, f_mr, f_mop, f_cis, f_csrr, alu, csr_model(),
            alu[31:0], f_mr, f_mw, 8'(m << off), f_rs2 << {off, 3'b000}, f_eb | f_inv};
  endfunction

  task automatic new_instr(input int kind, input int idx);
    logic [2:0] k;
    f_rs1 = rnd(64);
    f_rs2 = rnd(64);
    f_csrr = rnd(64);
    f_imm = rnd(64);
    f_pc = rnd(64);
    f_s1 = 1'(rnd(1));
    f_s2 = 2'(rnd(2));
    f_wc = 1'(rnd(1));
    f_op = 5'(rnd(5) % 11);
    f_rd = 5'(rnd(5));
    f_csr = 12'(rnd(12));
    f_gw = 1'(rnd(1));
    f_cw = 1'(rnd(1));
    f_cis = 1'(rnd(1));
    k = 3'(rnd(3) % 6);
    f_cop = (k < 3'd3) ? k + 3'd1 : k + 3'd2;
    f_mr = 1'(rnd(1));
    f_mw = !f_mr && 1'(rnd(1));
    f_mop = 3'(rnd(2));
    f_eb = (rnd(4) == 0);
    f_inv = (rnd(4) == 0);
    if (kind == 1) begin  // store sweep with size idx/8 at offset idx%8
      f_mw = 1'b1;
      f_mr = 1'b0;
      f_op = ALU_ADD;
      f_s1 = 1'b0;
      f_s2 = SRC2_IMM;
      f_wc = 1'b0;
      f_mop = 3'(idx / 8);
      f_imm = 64'(idx % 8);
      f_rs1 = {f_rs1[63:3], 3'b000};
    end
    ds_bus = {f_rs1, f_rs2, f_csrr, f_imm, f_pc, f_s1, f_s2, f_wc, f_op, f_rd, f_csr,
              f_gw, f_cw, f_mr, f_mw, f_mop, f_cis, f_cop, f_eb, f_inv};
  endtask

  task automatic check(input string name, input logic [215:0] got, input logic [215:0] exp);
    assert (got === exp) else begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic run_test(input string name, input int kind, input int n, input bit hs_rand);
    int sent;
    int err0;
    sent = 0;
    err0 = errors;
    while (sent < n) begin
      @(posedge clk);
      #2;
      if (acc) sent++;
      ms_allowin = hs_rand ? (rnd(2) != 0) : 1'b1;
      if (!ds_valid || acc) begin
        ds_valid = (sent < n) && (hs_rand ? (rnd(2) != 0) : 1'b1);
        if (ds_valid) new_instr(kind, sent);
      end
    end
    ms_allowin = 1'b1;  // drain
    while (exp_q.size() != 0) @(posedge clk);
    @(posedge clk);
    if (errors == err0) tests_passed++;
    else tests_failed++;
    $display("%s: %0d transfers, %0d errors", name, n, errors - err0);
  endtask

  // scoreboard sampled mid-cycle
  always @(negedge clk) begin
    logic [ITEM_WD-1:0] h;
    if (rst_n) begin
      acc = ds_valid && es_allowin;
      // queue depth is the stage occupancy
      check("o_es_allowin", 216'(es_allowin), 216'(exp_q.size() == 0 || ms_allowin));
      check("o_es_to_ms_valid", 216'(es_valid), 216'(exp_q.size() != 0));
      if (es_valid) begin
        if (exp_q.size() != 0) begin
          h = exp_q[0];
          check("o_es_to_ms_bus", 216'(es_bus), 216'(h[ITEM_WD-1:107]));
          check("o_data_sram_addr", 216'(sram_addr), 216'(h[106:75]));
          check("o_data_sram_ren", 216'(sram_ren), 216'(h[74]));
          check("o_data_sram_wen", 216'(sram_wen), 216'(h[73]));
          check("o_data_sram_wmask", 216'(sram_wmask), 216'(h[72:65]));
          check("o_data_sram_wdata", 216'(sram_wdata), 216'(h[64:1]));
          check("o_halt", 216'(halt), 216'(h[0]));
          if (ms_allowin) void'(exp_q.pop_front());
        end
      end else begin
        check("o_halt", 216'(halt), 216'(0));
        check("o_data_sram_ren", 216'(sram_ren), 216'(0));
        check("o_data_sram_wen", 216'(sram_wen), 216'(0));
      end
      if (acc) exp_q.push_back(expected_item());
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout, run still busy after %0d cycles", LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    rst_n = 1'b0;
    ds_valid = 1'b0;
    ms_allowin = 1'b0;
    ds_bus = '0;
    lfsr = 32'h96df;
    repeat (8) @(posedge clk);
    #2 rst_n = 1'b1;
    run_test("alu_csr_full_rate", 0, N_ALU, 1'b0);
    run_test("store_lanes", 1, N_STORE, 1'b0);
    run_test("random_handshake", 0, N_HS, 1'b1);
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_exu.sv
rtl/ex_lsu_store.sv
rtl/ex_stage.sv
bench/ex_stage_asserts.sv
bench/ex_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= ex_stage_tb
FILELIST  ?= compile.f
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
